// File: compile.f
hdl/channel_pkg.sv
hdl/slot_allocator.sv
hdl/slot_sequencer.sv
hdl/ca_code_gen.sv
hdl/carrier_mixer.sv
hdl/correlator_bank.sv
hdl/channel_top.sv
dv/channel_assert.sv
dv/channel_tb.sv

// File: dv/channel_assert.sv
`timescale 1ns/1ps

module channel_assert #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     sample_valid_i,
   input  logic                     slot_available_o,
   input  logic                     acc_valid_o,
   input  channel_pkg::acc_result_t acc_o
);

   // Bit j holds the sample strobe seen j+1 edges back.
   logic [NUM_SLOTS+1:0] strobe_hist;

   always_ff @(posedge clk) begin
      if (!rst_n_i)
         strobe_hist <= '0;
      else
         strobe_hist <= {strobe_hist[NUM_SLOTS:0], sample_valid_i};
   end

   //////////////////////////////////////////////////////////////////////
   // Output protocol
   //////////////////////////////////////////////////////////////////////

   reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !acc_valid_o)
      else $error("acc_valid_o high after a reset cycle");

   // A dump for slot k leaves 3+k cycles after its sample.
   result_after_sample: assert property (@(posedge clk) disable iff (!rst_n_i)
      acc_valid_o |-> |strobe_hist[NUM_SLOTS+1:2])
      else $error("acc_valid_o without a recent sample strobe");

   prn_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
      acc_valid_o |-> acc_o.prn != '0)
      else $error("result tagged with PRN zero");

   // Slots are never released.
   available_stays_low: assert property (@(posedge clk) disable iff (!rst_n_i)
      !slot_available_o |=> !slot_available_o)
      else $error("slot_available_o rose after all slots were taken");

endmodule

bind channel_top channel_assert #(.NUM_SLOTS(NUM_SLOTS)) u_assert (
   .clk(clk), .rst_n_i(rst_n_i), .sample_valid_i(sample_valid_i),
   .slot_available_o(slot_available_o), .acc_valid_o(acc_valid_o), .acc_o(acc_o));

// File: dv/channel_tb.sv
`timescale 1ns/1ps

module channel_tb;
   import channel_pkg::*;

   localparam int     NUM_SLOTS      = 4;
   localparam int     ACC_LEN        = 20;
   localparam phase_t IF_INC         = 16'd4660;
   localparam int     NUM_SAMPLES    = 200;
   localparam int     GAP            = 6;
   localparam int     TIMEOUT_CYCLES = NUM_SAMPLES * GAP + 200;
   localparam int     SEED           = 4;

   logic        clk;
   logic        rst_n_i;
   logic        sample_valid_i;
   sample_t     sample_i;
   logic        init_i;
   prn_t        init_prn_i;
   doppler_t    init_doppler_i;
   logic        slot_available_o;
   logic        acc_valid_o;
   acc_result_t acc_o;

   // Reference model state, one entry per slot.
   logic        m_active [NUM_SLOTS];
   logic        m_pending [NUM_SLOTS];
   prn_t        m_prn [NUM_SLOTS];
   doppler_t    m_dop [NUM_SLOTS];
   lfsr_t       m_g1 [NUM_SLOTS];
   lfsr_t       m_g2 [NUM_SLOTS];
   phase_t      m_phase [NUM_SLOTS];
   acc_t        m_acc_i [NUM_SLOTS];
   acc_t        m_acc_q [NUM_SLOTS];
   int          m_count;
   acc_result_t exp_q [$];
   prn_t        ignored_prn;
   int          cycle_cnt;

   channel_top #(.NUM_SLOTS(NUM_SLOTS), .ACC_LEN(ACC_LEN), .IF_INC(IF_INC)) dut0 (
      .clk(clk), .rst_n_i(rst_n_i),
      .sample_valid_i(sample_valid_i), .sample_i(sample_i),
      .init_i(init_i), .init_prn_i(init_prn_i), .init_doppler_i(init_doppler_i),
      .slot_available_o(slot_available_o), .acc_valid_o(acc_valid_o), .acc_o(acc_o));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
         fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Stage n sits in bit n-1; feedback enters at stage 1.
   function automatic logic lfsr_stage(input lfsr_t g, input int n);
      return g[n - 1];
   endfunction

   function automatic lfsr_t g1_step(input lfsr_t g);
      logic fb;
      fb = lfsr_stage(g, 3) ^ lfsr_stage(g, 10);
      return {g[8:0], fb};
   endfunction

   function automatic lfsr_t g2_step(input lfsr_t g);
      logic fb;
      fb = lfsr_stage(g, 2) ^ lfsr_stage(g, 3) ^ lfsr_stage(g, 6) ^
           lfsr_stage(g, 8) ^ lfsr_stage(g, 9) ^ lfsr_stage(g, 10);
      return {g[8:0], fb};
   endfunction

   function automatic logic prompt_chip(input lfsr_t g1, input lfsr_t g2, input prn_t prn);
      logic [7:0] taps;
      taps = G2_TAPS[int'(prn) - 1];
      return lfsr_stage(g1, 10) ^ lfsr_stage(g2, int'(taps[7:4])) ^
             lfsr_stage(g2, int'(taps[3:0]));
   endfunction

   function automatic logic model_available();
      logic free;
      free = 1'b0;
      for (int k = 0; k < NUM_SLOTS; k++)
         free = free | !m_active[k];
      return free;
   endfunction

   // A PRN that no claimed slot uses, so result tags stay unambiguous.
   function automatic prn_t unused_prn();
      prn_t pick;
      logic taken;
      do begin
         pick  = prn_t'($urandom_range(32, 1));
         taken = 1'b0;
         for (int k = 0; k < NUM_SLOTS; k++)
            taken = taken | (m_active[k] && m_prn[k] == pick);
      end while (taken);
      return pick;
   endfunction

   task automatic model_claim(input prn_t prn, input doppler_t dop);
      logic done;
      done = 1'b0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         if (!done && !m_active[k]) begin
            m_active[k]  = 1'b1;
            m_pending[k] = 1'b1;
            m_prn[k]     = prn;
            m_dop[k]     = dop;
            done         = 1'b1;
         end
      end
   endtask

   task automatic model_sample(input sample_t s);
      logic        first;
      logic        last;
      logic        clear;
      logic        chip;
      int          wi;
      int          wq;
      acc_t        base_i;
      acc_t        base_q;
      acc_result_t res;
      first = (m_count == 0);
      last  = (m_count == ACC_LEN - 1);
      for (int k = 0; k < NUM_SLOTS; k++) begin
         if (m_active[k]) begin
            clear = first;
            if (m_pending[k]) begin
               m_g1[k]      = '1;
               m_g2[k]      = '1;
               m_phase[k]   = '0;
               m_pending[k] = 1'b0;
               clear        = 1'b1;
            end
            chip   = prompt_chip(m_g1[k], m_g2[k], m_prn[k]);
            wi     = int'(s) * int'(CARRIER_COS[m_phase[k][15:13]]);
            wq     = int'(s) * int'(CARRIER_SIN[m_phase[k][15:13]]);
            base_i = clear ? acc_t'(0) : m_acc_i[k];
            base_q = clear ? acc_t'(0) : m_acc_q[k];
            m_acc_i[k] = chip ? base_i - acc_t'(wi) : base_i + acc_t'(wi);
            m_acc_q[k] = chip ? base_q - acc_t'(wq) : base_q + acc_t'(wq);
            if (last) begin
               res.prn = m_prn[k];
               res.i   = m_acc_i[k];
               res.q   = m_acc_q[k];
               exp_q.push_back(res);
            end
            m_g1[k]    = g1_step(m_g1[k]);
            m_g2[k]    = g2_step(m_g2[k]);
            m_phase[k] = m_phase[k] + IF_INC + phase_t'(m_dop[k]);
         end
      end
      m_count = last ? 0 : m_count + 1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////////////////////////

   task automatic compare_result();
      acc_result_t want;
      if (acc_o.prn == ignored_prn) begin
         fail_run("A result carries the PRN of the ignored init.");
      end else if (exp_q.size() == 0) begin
         fail_run("acc_valid_o pulsed while no result was expected.");
      end else begin
         want = exp_q.pop_front();
         check_value("acc_o.prn", 32'(acc_o.prn), 32'(want.prn));
         check_value("acc_o.i", 32'(acc_o.i), 32'(want.i));
         check_value("acc_o.q", 32'(acc_o.q), 32'(want.q));
      end
   endtask

   task automatic watch_results();
      forever begin
         @(posedge clk);
         if (rst_n_i && acc_valid_o)
            compare_result();
      end
   endtask

   task automatic count_cycles();
      forever begin
         @(posedge clk);
         cycle_cnt++;
         if (cycle_cnt > TIMEOUT_CYCLES)
            fail_run("Timeout: the run went past its cycle limit.");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // The first period ends with no slot claimed.
   // Slots 0 and 1 near the next period end, two mid-period claims, then one extra.
   function automatic logic init_after(input int n);
      return n == 38 || n == 39 || n == 104 || n == 111 || n == 130;
   endfunction

   task automatic run_sample(input int n);
      sample_t  s;
      logic     do_init;
      prn_t     prn;
      doppler_t dop;
      s       = sample_t'($urandom);
      do_init = init_after(n);
      for (int j = 0; j < GAP; j++) begin
         @(posedge clk);
         sample_valid_i <= (j == 0);
         sample_i       <= s;
         init_i         <= do_init && (j == GAP - 1);
         if (j == 0)
            model_sample(s);
         if (j == 1)
            check_value("slot_available_o", 32'(slot_available_o), 32'(model_available()));
         // Init lands after the sweep is over, before the next sample.
         if (j == GAP - 1 && do_init) begin
            prn = unused_prn();
            dop = doppler_t'($urandom);
            init_prn_i     <= prn;
            init_doppler_i <= dop;
            if (model_available())
               model_claim(prn, dop);
            else
               ignored_prn = prn;
         end
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rst_n_i        = 1'b0;
      sample_valid_i = 1'b0;
      sample_i       = '0;
      init_i         = 1'b0;
      init_prn_i     = '0;
      init_doppler_i = '0;
      ignored_prn    = '0;
      cycle_cnt      = 0;
      m_count        = 0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         m_active[k]  = 1'b0;
         m_pending[k] = 1'b0;
      end
      fork
         watch_results();
         count_cycles();
      join_none
      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;
      for (int n = 0; n < NUM_SAMPLES; n++)
         run_sample(n);
      for (int d = 0; d < 20 && exp_q.size() != 0; d++)
         @(posedge clk);
      if (exp_q.size() == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         fail_run("Expected results were still missing at the end of the run.");
      end
   end

endmodule

// File: hdl/ca_code_gen.sv
`timescale 1ns/1ps

module ca_code_gen #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  channel_pkg::slot_t     slot_i,
   input  logic                   slot_stb_i,
   input  channel_pkg::slot_cfg_t cfg_i,
   output logic                   chip_o
);
   import channel_pkg::*;

   localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

   // Stage n of each register sits in bit n-1.
   lfsr_t            g1_q [NUM_SLOTS];
   lfsr_t            g2_q [NUM_SLOTS];

   logic [IDX_W-1:0] cur_idx;
   lfsr_t            g1_cur;
   lfsr_t            g2_cur;
   lfsr_t            g1_next;
   lfsr_t            g2_next;
   logic [4:0]       tap_idx;
   logic [7:0]       taps;
   logic             chip;

   assign cur_idx = slot_i[IDX_W-1:0];

   // A new claim restarts the code from the all-ones state.
   assign g1_cur = cfg_i.init ? LFSR_INIT : g1_q[cur_idx];
   assign g2_cur = cfg_i.init ? LFSR_INIT : g2_q[cur_idx];

   // PRN-selected G2 phase taps.
   assign tap_idx = 5'(cfg_i.prn - 6'd1);
   assign taps    = G2_TAPS[tap_idx];
   assign chip    = g1_cur[9] ^ g2_cur[taps[7:4] - 4'd1] ^ g2_cur[taps[3:0] - 4'd1];

   // G1 is 1 + x^3 + x^10, G2 is 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10.
   assign g1_next = {g1_cur[8:0], g1_cur[2] ^ g1_cur[9]};
   assign g2_next = {g2_cur[8:0],
                     g2_cur[1] ^ g2_cur[2] ^ g2_cur[5] ^ g2_cur[7] ^ g2_cur[8] ^ g2_cur[9]};

   always_ff @(posedge clk) begin
      if (slot_stb_i && cfg_i.active) begin
         g1_q[cur_idx] <= g1_next;
         g2_q[cur_idx] <= g2_next;
      end
   end

   // One chip per sample goes to stage 1.
   always_ff @(posedge clk) begin
      if (!rst_n_i)
         chip_o <= 1'b0;
      else
         chip_o <= chip;
   end

endmodule

// File: hdl/carrier_mixer.sv
`timescale 1ns/1ps

module carrier_mixer #(
   parameter int                  NUM_SLOTS = 4,
   parameter channel_pkg::phase_t IF_INC    = 16'd4660
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  channel_pkg::slot_t       slot_i,
   input  logic                     slot_stb_i,
   input  channel_pkg::slot_cfg_t   cfg_i,
   input  channel_pkg::sample_t     sample_i,
   input  logic                     period_first_i,
   input  logic                     period_last_i,
   output channel_pkg::stage_ctrl_t ctrl_o,
   output channel_pkg::wipe_t       wipe_o
);
   import channel_pkg::*;

   localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

   phase_t           phase_q [NUM_SLOTS];

   logic [IDX_W-1:0] cur_idx;
   phase_t           phase_cur;
   phase_t           phase_next;
   logic [2:0]       lut_idx;
   carrier_t         cos_val;
   carrier_t         sin_val;

   assign cur_idx = slot_i[IDX_W-1:0];

   // Phase restarts at zero on a fresh claim.
   assign phase_cur = cfg_i.init ? '0 : phase_q[cur_idx];

   // Step is the IF plus the signed Doppler, wrapping at 2^16.
   assign phase_next = phase_cur + IF_INC + phase_t'(cfg_i.doppler);

   assign lut_idx = phase_cur[15:13];
   assign cos_val = CARRIER_COS[lut_idx];
   assign sin_val = CARRIER_SIN[lut_idx];

   always_ff @(posedge clk) begin
      if (slot_stb_i && cfg_i.active)
         phase_q[cur_idx] <= phase_next;
   end

   //////////////////////////////////////////////////////////////////////
   // Stage 1 registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      wipe_o.i <= wiped_t'(sample_i) * wiped_t'(cos_val);
      wipe_o.q <= wiped_t'(sample_i) * wiped_t'(sin_val);
   end

   // Accumulation restarts on the period start or on the slot's first sample.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ctrl_o <= '0;
      end else begin
         ctrl_o.valid <= slot_stb_i && cfg_i.active;
         ctrl_o.slot  <= slot_i;
         ctrl_o.prn   <= cfg_i.prn;
         ctrl_o.clear <= cfg_i.init || period_first_i;
         ctrl_o.dump  <= period_last_i;
      end
   end

endmodule

// File: hdl/channel_pkg.sv
package channel_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // Upper bound on the number of time-shared slots.
   localparam int MAX_SLOTS = 8;

   typedef logic        [$clog2(MAX_SLOTS)-1:0] slot_t;
   typedef logic        [5:0]                   prn_t;
   typedef logic signed [2:0]                   sample_t;
   typedef logic signed [11:0]                  doppler_t;
   typedef logic        [15:0]                  phase_t;
   typedef logic signed [2:0]                   carrier_t;
   typedef logic signed [5:0]                   wiped_t;
   typedef logic signed [19:0]                  acc_t;
   typedef logic        [9:0]                   lfsr_t;

   // G1 and G2 load value at the start of a code period.
   localparam lfsr_t LFSR_INIT = '1;

   //////////////////////////////////////////////////////////////////////
   // Pipeline structs
   //////////////////////////////////////////////////////////////////////

   // Settings of the slot currently in stage 0.
   typedef struct packed {
      logic     active;
      logic     init;
      prn_t     prn;
      doppler_t doppler;
   } slot_cfg_t;

   // Control that follows one slot item down the pipeline.
   typedef struct packed {
      logic  valid;
      slot_t slot;
      prn_t  prn;
      logic  clear;
      logic  dump;
   } stage_ctrl_t;

   typedef struct packed {
      wiped_t i;
      wiped_t q;
   } wipe_t;

   typedef struct packed {
      prn_t prn;
      acc_t i;
      acc_t q;
   } acc_result_t;

   //////////////////////////////////////////////////////////////////////
   // Tables
   //////////////////////////////////////////////////////////////////////

   // Carrier values indexed by the top three phase bits.
   localparam carrier_t CARRIER_COS [8] = '{
      3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1, 3'sd0, 3'sd1
   };

   // Sine lags cosine by a quarter turn.
   localparam carrier_t CARRIER_SIN [8] = '{
      3'sd0, 3'sd1, 3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1
   };

   // G2 output taps. Entry n holds PRN n+1, upper nibble first stage,
   // lower nibble second stage.
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2A, 8'h18, 8'h29,
      8'h3A, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9A,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8A, 8'h16, 8'h27, 8'h38, 8'h49
   };

endpackage

// File: hdl/channel_top.sv
`timescale 1ns/1ps

module channel_top #(
   parameter int                  NUM_SLOTS = 4,
   parameter int                  ACC_LEN   = 1023,
   parameter channel_pkg::phase_t IF_INC    = 16'd4660
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     sample_valid_i,
   input  channel_pkg::sample_t     sample_i,
   input  logic                     init_i,
   input  channel_pkg::prn_t        init_prn_i,
   input  channel_pkg::doppler_t    init_doppler_i,
   output logic                     slot_available_o,
   output logic                     acc_valid_o,
   output channel_pkg::acc_result_t acc_o
);
   import channel_pkg::*;

   // Stage 0 signals.
   slot_t       slot_s0;
   logic        slot_stb_s0;
   sample_t     sample_s0;
   logic        period_first_s0;
   logic        period_last_s0;
   slot_cfg_t   cfg_s0;

   // Stage 1 signals.
   logic        chip_s1;
   stage_ctrl_t ctrl_s1;
   wipe_t       wipe_s1;

   //////////////////////////////////////////////////////////////////////
   // Stage 0: slot sweep and slot settings
   //////////////////////////////////////////////////////////////////////

   slot_sequencer #(.NUM_SLOTS(NUM_SLOTS), .ACC_LEN(ACC_LEN)) u_seq (
      .clk(clk), .rst_n_i(rst_n_i),
      .sample_valid_i(sample_valid_i), .sample_i(sample_i),
      .slot_o(slot_s0), .slot_stb_o(slot_stb_s0), .sample_o(sample_s0),
      .period_first_o(period_first_s0), .period_last_o(period_last_s0));

   slot_allocator #(.NUM_SLOTS(NUM_SLOTS)) u_alloc (
      .clk(clk), .rst_n_i(rst_n_i),
      .init_i(init_i), .init_prn_i(init_prn_i), .init_doppler_i(init_doppler_i),
      .slot_i(slot_s0), .slot_stb_i(slot_stb_s0),
      .cfg_o(cfg_s0), .slot_available_o(slot_available_o));

   // Code and carrier state update in stage 0 and register into stage 1.
   ca_code_gen #(.NUM_SLOTS(NUM_SLOTS)) u_code (
      .clk(clk), .rst_n_i(rst_n_i),
      .slot_i(slot_s0), .slot_stb_i(slot_stb_s0), .cfg_i(cfg_s0),
      .chip_o(chip_s1));

   carrier_mixer #(.NUM_SLOTS(NUM_SLOTS), .IF_INC(IF_INC)) u_mix (
      .clk(clk), .rst_n_i(rst_n_i),
      .slot_i(slot_s0), .slot_stb_i(slot_stb_s0), .cfg_i(cfg_s0),
      .sample_i(sample_s0),
      .period_first_i(period_first_s0), .period_last_i(period_last_s0),
      .ctrl_o(ctrl_s1), .wipe_o(wipe_s1));

   //////////////////////////////////////////////////////////////////////
   // Stage 1: accumulate, dump into stage 2
   //////////////////////////////////////////////////////////////////////

   correlator_bank #(.NUM_SLOTS(NUM_SLOTS)) u_corr (
      .clk(clk), .rst_n_i(rst_n_i),
      .ctrl_i(ctrl_s1), .wipe_i(wipe_s1), .chip_i(chip_s1),
      .acc_valid_o(acc_valid_o), .acc_o(acc_o));

endmodule

// File: hdl/correlator_bank.sv
`timescale 1ns/1ps

module correlator_bank #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  channel_pkg::stage_ctrl_t ctrl_i,
   input  channel_pkg::wipe_t       wipe_i,
   input  logic                     chip_i,
   output logic                     acc_valid_o,
   output channel_pkg::acc_result_t acc_o
);
   import channel_pkg::*;

   localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

   // Prompt I/Q accumulators, one pair per slot.
   acc_t             acc_i_q [NUM_SLOTS];
   acc_t             acc_q_q [NUM_SLOTS];

   logic [IDX_W-1:0] cur_idx;
   acc_t             base_i;
   acc_t             base_q;
   acc_t             term_i;
   acc_t             term_q;
   acc_t             sum_i;
   acc_t             sum_q;

   assign cur_idx = ctrl_i.slot[IDX_W-1:0];

   assign base_i = ctrl_i.clear ? '0 : acc_i_q[cur_idx];
   assign base_q = ctrl_i.clear ? '0 : acc_q_q[cur_idx];

   assign term_i = acc_t'(wipe_i.i);
   assign term_q = acc_t'(wipe_i.q);

   // Code wipe-off. A one chip flips the sign of the carrier-wiped sample.
   assign sum_i = chip_i ? base_i - term_i : base_i + term_i;
   assign sum_q = chip_i ? base_q - term_q : base_q + term_q;

   always_ff @(posedge clk) begin
      if (ctrl_i.valid) begin
         acc_i_q[cur_idx] <= sum_i;
         acc_q_q[cur_idx] <= sum_q;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stage 2 dump
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i)
         acc_valid_o <= 1'b0;
      else
         acc_valid_o <= ctrl_i.valid && ctrl_i.dump;
   end

   // Result holds until the next dump.
   always_ff @(posedge clk) begin
      if (ctrl_i.valid && ctrl_i.dump) begin
         acc_o.prn <= ctrl_i.prn;
         acc_o.i   <= sum_i;
         acc_o.q   <= sum_q;
      end
   end

endmodule

// File: hdl/slot_allocator.sv
`timescale 1ns/1ps

module slot_allocator #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   init_i,
   input  channel_pkg::prn_t      init_prn_i,
   input  channel_pkg::doppler_t  init_doppler_i,
   input  channel_pkg::slot_t     slot_i,
   input  logic                   slot_stb_i,
   output channel_pkg::slot_cfg_t cfg_o,
   output logic                   slot_available_o
);
   import channel_pkg::*;

   localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

   logic [NUM_SLOTS-1:0] active_q;
   logic [NUM_SLOTS-1:0] pending_q;
   prn_t                 prn_q [NUM_SLOTS];
   doppler_t             doppler_q [NUM_SLOTS];

   logic                 free_found;
   slot_t                free_slot;
   logic [IDX_W-1:0]     cur_idx;
   logic [IDX_W-1:0]     free_idx;

   // Lowest free slot wins; scan from the top so the last hit is lowest.
   always_comb begin
      free_found = 1'b0;
      free_slot  = '0;
      for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
         if (!active_q[s]) begin
            free_found = 1'b1;
            free_slot  = slot_t'(s);
         end
      end
   end

   assign cur_idx          = slot_i[IDX_W-1:0];
   assign free_idx         = free_slot[IDX_W-1:0];
   assign slot_available_o = free_found;

   // Stage 0 view of the swept slot.
   assign cfg_o = '{active:  active_q[cur_idx],
                    init:    pending_q[cur_idx],
                    prn:     prn_q[cur_idx],
                    doppler: doppler_q[cur_idx]};

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         active_q  <= '0;
         pending_q <= '0;
      end else begin
         // First sample seen by the slot consumes the pending init.
         if (slot_stb_i && active_q[cur_idx])
            pending_q[cur_idx] <= 1'b0;
         if (init_i && free_found) begin
            active_q[free_idx]  <= 1'b1;
            pending_q[free_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (init_i && free_found) begin
         prn_q[free_idx]     <= init_prn_i;
         doppler_q[free_idx] <= init_doppler_i;
      end
   end

endmodule

// File: hdl/slot_sequencer.sv
`timescale 1ns/1ps

module slot_sequencer #(
   parameter int NUM_SLOTS = 4,
   parameter int ACC_LEN   = 1023
) (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 sample_valid_i,
   input  channel_pkg::sample_t sample_i,
   output channel_pkg::slot_t   slot_o,
   output logic                 slot_stb_o,
   output channel_pkg::sample_t sample_o,
   output logic                 period_first_o,
   output logic                 period_last_o
);
   import channel_pkg::*;

   localparam int    CNT_W     = $clog2(ACC_LEN + 1);
   localparam slot_t LAST_SLOT = slot_t'(NUM_SLOTS - 1);

   logic [CNT_W-1:0] count_q;
   logic             first_now;
   logic             last_now;

   assign first_now = (count_q == '0);
   assign last_now  = (count_q == CNT_W'(ACC_LEN - 1));

   // Sweep every slot once per sample, starting the cycle after the strobe.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         slot_stb_o <= 1'b0;
         slot_o     <= '0;
      end else if (sample_valid_i) begin
         slot_stb_o <= 1'b1;
         slot_o     <= '0;
      end else if (slot_stb_o) begin
         slot_stb_o <= (slot_o != LAST_SLOT);
         slot_o     <= (slot_o == LAST_SLOT) ? '0 : slot_o + slot_t'(1);
      end
   end

   // Period position of the captured sample, held for the whole sweep.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         count_q        <= '0;
         period_first_o <= 1'b0;
         period_last_o  <= 1'b0;
      end else if (sample_valid_i) begin
         count_q        <= last_now ? '0 : count_q + CNT_W'(1);
         period_first_o <= first_now;
         period_last_o  <= last_now;
      end
   end

   always_ff @(posedge clk) begin
      if (sample_valid_i)
         sample_o <= sample_i;
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the correlator channel testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
   --top-module channel_tb \
   -Mdir obj_dir -o channel_sim \
   -f compile.f

./obj_dir/channel_sim
